//--- include/qdr_sniffer_macros.svh
`ifndef QDR_SNIFFER_MACROS_SVH
`define QDR_SNIFFER_MACROS_SVH

// ====================================================================
// qdr port geometry
// ====================================================================

// word address into the qdr array
`define QDR_ADDR_WIDTH 21
// one half of a two-beat burst
`define QDR_DATA_WIDTH 36
// byte-write bits per half, one per 18-bit group
`define QDR_BW_WIDTH 2
// read strobe to rd_dvld, fixed by the controller
`define QDR_LATENCY 10

// ====================================================================
// host address windows, base inclusive, high exclusive
// ====================================================================

// backdoor into the qdr array
`define SNIFF_BASE 32'h0100_0000
`define SNIFF_HIGH 32'h0200_0000
// status, reset control and scratch
`define CFG_BASE 32'h0000_1000
`define CFG_HIGH 32'h0000_1010

`endif

//--- src/qdr_types_pkg.sv
`include "qdr_sniffer_macros.svh"

package qdr_types_pkg;

  // word address on the controller port
  typedef logic [`QDR_ADDR_WIDTH-1:0] qdr_addr_t;

  // full burst word, high half in the upper bits
  typedef logic [2*`QDR_DATA_WIDTH-1:0] qdr_word_t;

  // byte writes, 1:0 low half and 3:2 high half
  typedef logic [2*`QDR_BW_WIDTH-1:0] qdr_be_t;

  // slot arbiter states
  // fabric owns the port in arb_slave
  // arb_slave_wait lets a pending fabric strobe drain
  // arb_backdoor is the single stolen slot
  typedef enum logic [1:0] {
    arb_slave,
    arb_slave_wait,
    arb_backdoor,
    arb_backdoor_wait
  } arb_state_t;

endpackage

//--- src/host_bus_pkg.sv
package host_bus_pkg;

  // byte address as seen on the host bus
  typedef logic [31:0] host_addr_t;

  // one host data word
  typedef logic [31:0] host_data_t;

  // byte enables, bit k for byte lane k
  typedef logic [3:0] host_be_t;

  // status window registers by word offset
  // offset 3 is unused and reads zero
  typedef enum logic [1:0] {
    cfg_status  = 2'd0,
    cfg_ctrl    = 2'd1,
    cfg_scratch = 2'd2
  } cfg_reg_t;

endpackage

//--- src/host_slave_port.sv
`include "qdr_sniffer_macros.svh"

module host_slave_port (
  input  logic                     qdr_clk,
  input  logic                     qdr_rst,
  input  host_bus_pkg::host_addr_t host_addr,
  input  host_bus_pkg::host_be_t   host_be,
  input  host_bus_pkg::host_data_t host_wdata,
  input  logic                     host_rnw,
  input  logic                     host_select,
  input  logic                     bd_done,
  input  host_bus_pkg::host_data_t bd_rdata,
  input  logic                     cfg_done,
  input  host_bus_pkg::host_data_t cfg_rdata,
  output host_bus_pkg::host_data_t host_rdata,
  output logic                     host_ack,
  output logic                     host_tout_sup,
  output logic                     bd_en,
  output logic                     cfg_en,
  output host_bus_pkg::host_addr_t local_addr,
  output host_bus_pkg::host_be_t   local_be,
  output host_bus_pkg::host_data_t local_wdata,
  output logic                     local_rnw
);

  import host_bus_pkg::*;

  logic       bd_match;
  logic       cfg_match;
  logic       sel_state;
  host_data_t done_rdata;

  // ====================================================================
  // address decode
  // ====================================================================

  always_comb begin
    bd_match  = (host_addr >= `SNIFF_BASE) && (host_addr < `SNIFF_HIGH);
    cfg_match = (host_addr >= `CFG_BASE) && (host_addr < `CFG_HIGH);
    // offset into whichever window matched
    // host holds address until ack so this stays valid for the block
    if (bd_match) begin
      local_addr = host_addr - `SNIFF_BASE;
    end else begin
      local_addr = host_addr - `CFG_BASE;
    end
    local_be    = host_be;
    local_wdata = host_wdata;
    local_rnw   = host_rnw;
  end

  // ====================================================================
  // transfer start
  // ====================================================================

  // sel_state marks an open decoded transfer
  // enable pulses one cycle after the first matching select
  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      sel_state <= 1'b0;
      bd_en     <= 1'b0;
      cfg_en    <= 1'b0;
    end else begin
      bd_en  <= 1'b0;
      cfg_en <= 1'b0;
      if (!sel_state && host_select && (bd_match || cfg_match)) begin
        sel_state <= 1'b1;
        bd_en     <= bd_match;
        cfg_en    <= cfg_match;
      end
      // ack closes the transfer, so does the host giving up
      if (host_ack || !host_select) begin
        sel_state <= 1'b0;
      end
    end
  end

  // keeps the bus timeout off while a block works on it
  assign host_tout_sup = sel_state;

  // ====================================================================
  // ack and read data
  // ====================================================================

  // only one block is ever enabled, so the done pulses never overlap
  always_comb begin
    host_ack   = bd_done | cfg_done;
    done_rdata = bd_done ? bd_rdata : cfg_rdata;
    // bus is wired-or, drive zero outside the ack cycle
    host_rdata = host_ack ? done_rdata : '0;
  end

endmodule

//--- src/backdoor_bridge.sv
`include "qdr_sniffer_macros.svh"

module backdoor_bridge (
  input  logic                     qdr_clk,
  input  logic                     qdr_rst,
  input  logic                     bd_en,
  input  host_bus_pkg::host_addr_t local_addr,
  input  host_bus_pkg::host_be_t   local_be,
  input  host_bus_pkg::host_data_t local_wdata,
  input  logic                     local_rnw,
  input  logic                     bd_grant,
  input  qdr_types_pkg::qdr_word_t master_rd_data,
  input  logic                     master_rd_dvld,
  output logic                     bd_req,
  output logic                     bd_r,
  output logic                     bd_w,
  output qdr_types_pkg::qdr_addr_t bd_addr,
  output qdr_types_pkg::qdr_word_t bd_d,
  output qdr_types_pkg::qdr_be_t   bd_be,
  output logic                     bd_done,
  output host_bus_pkg::host_data_t bd_rdata
);

  import qdr_types_pkg::*;
  import host_bus_pkg::*;

  localparam int half_w = `QDR_DATA_WIDTH;
  localparam int lat_w  = $clog2(`QDR_LATENCY);

  typedef enum logic [1:0] {
    bd_idle,
    bd_request,
    bd_read_wait
  } bd_state_t;

  bd_state_t                state;
  logic [lat_w-1:0]         lat_cnt;
  logic                     rd_sel;
  logic                     rd_hit;
  logic [half_w-1:0]        wr_half;
  logic [`QDR_BW_WIDTH-1:0] wr_bw;
  logic [half_w-1:0]        rd_half;
  host_data_t               rd_word;

  // ====================================================================
  // lane mapping
  // ====================================================================

  // host byte k sits in bits 9k+7:9k of the half
  // ninth bit of each lane stays zero
  always_comb begin
    wr_half = '0;
    rd_half = rd_sel ? master_rd_data[half_w +: half_w] : master_rd_data[0 +: half_w];
    for (int k = 0; k < 4; k++) begin
      wr_half[9*k +: 8] = local_wdata[8*k +: 8];
      rd_word[8*k +: 8] = rd_half[9*k +: 8];
    end
    // one bw bit covers two byte lanes
    wr_bw = {local_be[3] | local_be[2], local_be[1] | local_be[0]};
  end

  // ====================================================================
  // request FSM
  // ====================================================================

  // around our slot the arbiter leaves a gap on each side,
  // so any dvld from latency-1 on is ours
  assign rd_hit = (state == bd_read_wait) && (lat_cnt == '0) && master_rd_dvld;

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      state   <= bd_idle;
      bd_req  <= 1'b0;
      bd_r    <= 1'b0;
      bd_w    <= 1'b0;
      bd_done <= 1'b0;
      lat_cnt <= '0;
    end else begin
      bd_done <= 1'b0;
      case (state)
        bd_idle: begin
          if (bd_en) begin
            bd_req <= 1'b1;
            bd_r   <= local_rnw;
            bd_w   <= !local_rnw;
            state  <= bd_request;
          end
        end
        bd_request: begin
          // hold everything until the arbiter takes the slot
          if (bd_grant) begin
            bd_req  <= 1'b0;
            lat_cnt <= lat_w'(`QDR_LATENCY - 2);
            if (bd_w) begin
              // write is done once issued
              bd_done <= 1'b1;
              state   <= bd_idle;
            end else begin
              state <= bd_read_wait;
            end
          end
        end
        bd_read_wait: begin
          if (lat_cnt != '0) begin
            lat_cnt <= lat_cnt - 1'b1;
          end
          if (rd_hit) begin
            bd_done <= 1'b1;
            state   <= bd_idle;
          end
        end
        default: begin
          state <= bd_idle;
        end
      endcase
    end
  end

  // command payload, taken once per host access
  always_ff @(posedge qdr_clk) begin
    if (bd_en && (state == bd_idle)) begin
      bd_addr <= local_addr[`QDR_ADDR_WIDTH+2:3];
      rd_sel  <= local_addr[2];
      // other half gets zero data and no byte writes
      if (local_addr[2]) begin
        bd_d  <= {wr_half, {half_w{1'b0}}};
        bd_be <= {wr_bw, {`QDR_BW_WIDTH{1'b0}}};
      end else begin
        bd_d  <= {{half_w{1'b0}}, wr_half};
        bd_be <= {{`QDR_BW_WIDTH{1'b0}}, wr_bw};
      end
    end
    if (rd_hit) begin
      bd_rdata <= rd_word;
    end
  end

endmodule

//--- src/sniff_arbiter.sv
module sniff_arbiter (
  input  logic                     qdr_clk,
  input  logic                     qdr_rst,
  input  qdr_types_pkg::qdr_addr_t slave_addr,
  input  logic                     slave_wr_strb,
  input  qdr_types_pkg::qdr_word_t slave_wr_data,
  input  qdr_types_pkg::qdr_be_t   slave_wr_be,
  input  logic                     slave_rd_strb,
  input  logic                     bd_req,
  input  logic                     bd_r,
  input  logic                     bd_w,
  input  qdr_types_pkg::qdr_addr_t bd_addr,
  input  qdr_types_pkg::qdr_word_t bd_d,
  input  qdr_types_pkg::qdr_be_t   bd_be,
  output logic                     slave_ack,
  output logic                     bd_grant,
  output qdr_types_pkg::qdr_addr_t master_addr,
  output logic                     master_wr_strb,
  output qdr_types_pkg::qdr_word_t master_wr_data,
  output qdr_types_pkg::qdr_be_t   master_wr_be,
  output logic                     master_rd_strb
);

  import qdr_types_pkg::*;

  arb_state_t arb_state;
  logic       slave_strb;
  logic       fabric_data;

  assign slave_strb = slave_wr_strb | slave_rd_strb;

  // ====================================================================
  // slot state machine
  // ====================================================================

  // backdoor gets exactly one slot, then a gap, then fabric again
  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      arb_state <= arb_slave;
    end else begin
      case (arb_state)
        arb_slave: begin
          if (bd_req) begin
            // a fabric strobe this cycle is still taken
            if (slave_strb) begin
              arb_state <= arb_slave_wait;
            end else begin
              arb_state <= arb_backdoor;
            end
          end
        end
        arb_slave_wait: begin
          arb_state <= arb_backdoor;
        end
        arb_backdoor: begin
          arb_state <= arb_backdoor_wait;
        end
        arb_backdoor_wait: begin
          arb_state <= arb_slave;
        end
        default: begin
          arb_state <= arb_slave;
        end
      endcase
    end
  end

  // ====================================================================
  // command muxes
  // ====================================================================

  always_comb begin
    slave_ack = (arb_state == arb_slave);
    bd_grant  = (arb_state == arb_backdoor);
    // wr data lags a cycle behind the strobe, so fabric keeps it
    // through the wait state
    fabric_data = (arb_state == arb_slave) || (arb_state == arb_slave_wait);

    master_wr_strb = (slave_wr_strb && slave_ack) || (bd_w && bd_grant);
    master_rd_strb = (slave_rd_strb && slave_ack) || (bd_r && bd_grant);
    master_addr    = slave_ack ? slave_addr : bd_addr;
    master_wr_data = fabric_data ? slave_wr_data : bd_d;
    master_wr_be   = fabric_data ? slave_wr_be : bd_be;
  end

endmodule

//--- src/qdr_status_regs.sv
module qdr_status_regs (
  input  logic                     qdr_clk,
  input  logic                     qdr_rst,
  input  logic                     cfg_en,
  input  host_bus_pkg::host_addr_t local_addr,
  input  host_bus_pkg::host_data_t local_wdata,
  input  logic                     local_rnw,
  input  logic                     phy_rdy,
  input  logic                     cal_fail,
  output logic                     cfg_done,
  output host_bus_pkg::host_data_t cfg_rdata,
  output logic                     qdr_reset
);

  import host_bus_pkg::*;

  logic [1:0] phy_rdy_sync;
  logic [1:0] cal_fail_sync;
  host_data_t scratch;
  cfg_reg_t   reg_sel;
  logic       wr_en;

  // word offset within the 16 byte window
  always_comb begin
    reg_sel = cfg_reg_t'(local_addr[3:2]);
    wr_en   = cfg_en && !local_rnw;
  end

  // two flop sync on the phy flags
  always_ff @(posedge qdr_clk) begin
    phy_rdy_sync  <= {phy_rdy_sync[0], phy_rdy};
    cal_fail_sync <= {cal_fail_sync[0], cal_fail};
  end

  // ====================================================================
  // control and handshake
  // ====================================================================

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      cfg_done  <= 1'b0;
      qdr_reset <= 1'b0;
    end else begin
      cfg_done <= cfg_en;
      if (wr_en && (reg_sel == cfg_ctrl)) begin
        qdr_reset <= local_wdata[0];
      end
    end
  end

  // scratch and read data
  always_ff @(posedge qdr_clk) begin
    if (wr_en && (reg_sel == cfg_scratch)) begin
      scratch <= local_wdata;
    end
    if (cfg_en) begin
      case (reg_sel)
        cfg_status:  cfg_rdata <= {30'b0, cal_fail_sync[1], phy_rdy_sync[1]};
        cfg_ctrl:    cfg_rdata <= {31'b0, qdr_reset};
        cfg_scratch: cfg_rdata <= scratch;
        // unused offset
        default:     cfg_rdata <= '0;
      endcase
    end
  end

endmodule

//--- src/qdr_sniffer_top.sv
module qdr_sniffer_top (
  input  logic                     qdr_clk,
  input  logic                     qdr_rst,
  // host register bus
  input  host_bus_pkg::host_addr_t host_addr,
  input  host_bus_pkg::host_be_t   host_be,
  input  host_bus_pkg::host_data_t host_wdata,
  input  logic                     host_rnw,
  input  logic                     host_select,
  output host_bus_pkg::host_data_t host_rdata,
  output logic                     host_ack,
  output logic                     host_tout_sup,
  // fabric user port
  input  qdr_types_pkg::qdr_addr_t slave_addr,
  input  logic                     slave_wr_strb,
  input  qdr_types_pkg::qdr_word_t slave_wr_data,
  input  qdr_types_pkg::qdr_be_t   slave_wr_be,
  input  logic                     slave_rd_strb,
  output qdr_types_pkg::qdr_word_t slave_rd_data,
  output logic                     slave_rd_dvld,
  output logic                     slave_ack,
  // qdr controller user port
  output qdr_types_pkg::qdr_addr_t master_addr,
  output logic                     master_wr_strb,
  output qdr_types_pkg::qdr_word_t master_wr_data,
  output qdr_types_pkg::qdr_be_t   master_wr_be,
  output logic                     master_rd_strb,
  input  qdr_types_pkg::qdr_word_t master_rd_data,
  input  logic                     master_rd_dvld,
  input  logic                     phy_rdy,
  input  logic                     cal_fail,
  output logic                     qdr_reset
);

  import qdr_types_pkg::*;
  import host_bus_pkg::*;

  // host port to blocks
  logic       bd_en, cfg_en, local_rnw;
  host_addr_t local_addr;
  host_be_t   local_be;
  host_data_t local_wdata;
  logic       bd_done, cfg_done;
  host_data_t bd_rdata, cfg_rdata;

  // bridge to arbiter
  logic      bd_req, bd_r, bd_w, bd_grant;
  qdr_addr_t bd_addr;
  qdr_word_t bd_d;
  qdr_be_t   bd_be;

  // read return goes to the fabric untouched
  assign slave_rd_data = master_rd_data;
  assign slave_rd_dvld = master_rd_dvld;

  host_slave_port u_host_slave_port (
    .qdr_clk, .qdr_rst, .host_addr, .host_be, .host_wdata, .host_rnw, .host_select,
    .bd_done, .bd_rdata, .cfg_done, .cfg_rdata, .host_rdata, .host_ack, .host_tout_sup,
    .bd_en, .cfg_en, .local_addr, .local_be, .local_wdata, .local_rnw
  );

  backdoor_bridge u_backdoor_bridge (
    .qdr_clk, .qdr_rst, .bd_en, .local_addr, .local_be, .local_wdata, .local_rnw,
    .bd_grant, .master_rd_data, .master_rd_dvld, .bd_req, .bd_r, .bd_w, .bd_addr,
    .bd_d, .bd_be, .bd_done, .bd_rdata
  );

  sniff_arbiter u_sniff_arbiter (
    .qdr_clk, .qdr_rst, .slave_addr, .slave_wr_strb, .slave_wr_data, .slave_wr_be,
    .slave_rd_strb, .bd_req, .bd_r, .bd_w, .bd_addr, .bd_d, .bd_be, .slave_ack,
    .bd_grant, .master_addr, .master_wr_strb, .master_wr_data, .master_wr_be,
    .master_rd_strb
  );

  qdr_status_regs u_qdr_status_regs (
    .qdr_clk, .qdr_rst, .cfg_en, .local_addr, .local_wdata, .local_rnw, .phy_rdy,
    .cal_fail, .cfg_done, .cfg_rdata, .qdr_reset
  );

endmodule

//--- verification/qdr_mem_model.sv
`include "qdr_sniffer_macros.svh"

module qdr_mem_model (
  input  logic                     qdr_clk,
  input  logic                     qdr_rst,
  input  qdr_types_pkg::qdr_addr_t master_addr,
  input  logic                     master_wr_strb,
  input  qdr_types_pkg::qdr_word_t master_wr_data,
  input  qdr_types_pkg::qdr_be_t   master_wr_be,
  input  logic                     master_rd_strb,
  output qdr_types_pkg::qdr_word_t master_rd_data,
  output logic                     master_rd_dvld
);

  timeunit 1ns;
  timeprecision 1ps;

  import qdr_types_pkg::*;

  // sparse array, unwritten words read zero
  qdr_word_t                mem [qdr_addr_t];
  logic [`QDR_LATENCY-1:0]  vld_pipe;
  qdr_word_t                data_pipe [`QDR_LATENCY];

  always @(posedge qdr_clk) begin
    qdr_word_t upd;
    if (qdr_rst) begin
      vld_pipe <= '0;
    end else begin
      // read data taken at the strobe, delivered after the fixed latency
      vld_pipe     <= {vld_pipe[`QDR_LATENCY-2:0], master_rd_strb};
      data_pipe[0] <= mem.exists(master_addr) ? mem[master_addr] : '0;
      for (int i = 1; i < `QDR_LATENCY; i++) begin
        data_pipe[i] <= data_pipe[i-1];
      end
      if (master_wr_strb) begin
        upd = mem.exists(master_addr) ? mem[master_addr] : '0;
        // one bw bit per 18-bit group
        for (int g = 0; g < 4; g++) begin
          if (master_wr_be[g]) begin
            upd[18*g +: 18] = master_wr_data[18*g +: 18];
          end
        end
        mem[master_addr] = upd;
      end
    end
  end

  assign master_rd_dvld = vld_pipe[`QDR_LATENCY-1];
  assign master_rd_data = data_pipe[`QDR_LATENCY-1];

endmodule

//--- verification/qdr_sniffer_tb.sv
`include "qdr_sniffer_macros.svh"

module qdr_sniffer_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import qdr_types_pkg::*;
  import host_bus_pkg::*;

  logic       qdr_clk, qdr_rst;
  host_addr_t host_addr;
  host_be_t   host_be;
  host_data_t host_wdata, host_rdata;
  logic       host_rnw, host_select, host_ack, host_tout_sup;
  qdr_addr_t  slave_addr, master_addr;
  qdr_word_t  slave_wr_data, slave_rd_data, master_wr_data, master_rd_data;
  qdr_be_t    slave_wr_be, master_wr_be;
  logic       slave_wr_strb, slave_rd_strb, slave_rd_dvld, slave_ack;
  logic       master_wr_strb, master_rd_strb, master_rd_dvld;
  logic       phy_rdy, cal_fail, qdr_reset;

  int         errors = 0;
  int         timeouts = 0;
  integer     seed = 32'h759;
  qdr_word_t  mirror [qdr_addr_t];
  logic [32:0] host_exp [$];
  qdr_word_t  fab_exp [$];
  logic       rd_owner [$];
  int         fab_wr_sent = 0;
  int         fab_wr_seen = 0;
  int         low_run = 0;

  always #4 qdr_clk = ~qdr_clk;

  qdr_sniffer_top u_dut (.*);

  qdr_mem_model u_mem (
    .qdr_clk, .qdr_rst, .master_addr, .master_wr_strb, .master_wr_data,
    .master_wr_be, .master_rd_strb, .master_rd_data, .master_rd_dvld
  );

  // ====================================================================
  // reference model of the mapping rules
  // ====================================================================

  // host byte k lands at 9k+7:9k of the chosen half with a zero ninth bit
  function automatic qdr_word_t pack_word(input logic hi, input host_data_t d);
    logic [35:0] h;
    h = '0;
    for (int k = 0; k < 4; k++) begin
      h[9*k +: 8] = d[8*k +: 8];
    end
    return hi ? {h, 36'b0} : {36'b0, h};
  endfunction

  function automatic qdr_be_t pack_be(input logic hi, input host_be_t be);
    logic [1:0] bw;
    bw = {be[3] | be[2], be[1] | be[0]};
    return hi ? {bw, 2'b00} : {2'b00, bw};
  endfunction

  function automatic qdr_word_t apply_mask(input qdr_word_t old, input qdr_word_t d,
                                           input qdr_be_t be);
    qdr_word_t r;
    r = old;
    for (int g = 0; g < 4; g++) begin
      if (be[g]) begin
        r[18*g +: 18] = d[18*g +: 18];
      end
    end
    return r;
  endfunction

  function automatic host_data_t host_view(input qdr_word_t w, input logic hi);
    host_data_t r;
    for (int k = 0; k < 4; k++) begin
      r[8*k +: 8] = w[36*hi + 9*k +: 8];
    end
    return r;
  endfunction

  function automatic qdr_word_t mirror_get(input qdr_addr_t a);
    return mirror.exists(a) ? mirror[a] : '0;
  endfunction

  // ====================================================================
  // compare process
  // ====================================================================

  always @(posedge qdr_clk) begin
    logic [32:0] he;
    if (!qdr_rst) begin
      if (host_ack) begin
        if (host_tout_sup !== 1'b1) begin
          errors++;
          $display("error %0t host_tout_sup exp 1 got %b", $time, host_tout_sup);
        end
        if (host_exp.size() == 0) begin
          errors++;
          $display("host_ack came with no transfer open at %0t", $time);
        end else begin
          he = host_exp.pop_front();
          if (he[32] && host_rdata !== he[31:0]) begin
            errors++;
            $display("error %0t host_rdata exp %h got %h", $time, he[31:0], host_rdata);
          end
        end
      end else if (host_rdata !== '0) begin
        errors++;
        $display("error %0t host_rdata exp %h got %h", $time, 32'h0, host_rdata);
      end
      // which reads at the controller belong to the fabric
      if (master_rd_strb) begin
        rd_owner.push_back(slave_ack);
      end
      if (master_wr_strb && slave_ack) begin
        fab_wr_seen++;
      end
      if (slave_rd_dvld) begin
        if (rd_owner.size() == 0) begin
          errors++;
          $display("read data returned with no read outstanding at %0t", $time);
        end else if (rd_owner.pop_front()) begin
          if (fab_exp.size() == 0) begin
            errors++;
            $display("fabric read data with no fabric read pending at %0t", $time);
          end else if (slave_rd_data !== fab_exp[0]) begin
            errors++;
            $display("error %0t slave_rd_data exp %h got %h", $time, fab_exp[0],
                     slave_rd_data);
            void'(fab_exp.pop_front());
          end else begin
            void'(fab_exp.pop_front());
          end
        end
      end
      // fabric stall length per backdoor access
      low_run = slave_ack ? 0 : low_run + 1;
      if (low_run > 3) begin
        errors++;
        $display("slave_ack low for %0d cycles at %0t", low_run, $time);
      end
    end
  end

  // ====================================================================
  // stimulus tasks entered on a rising edge
  // ====================================================================

  task automatic host_access(input host_addr_t a, input logic rnw, input host_data_t wd,
                             input host_be_t be, input host_data_t exp);
    int n;
    host_exp.push_back({rnw, exp});
    host_addr   <= a;
    host_rnw    <= rnw;
    host_wdata  <= wd;
    host_be     <= be;
    host_select <= 1'b1;
    n = 0;
    do begin
      @(posedge qdr_clk);
      n++;
    end while (!host_ack && n < 100);
    if (!host_ack) begin
      timeouts++;
      $display("no host_ack for address %h within 100 cycles", a);
      void'(host_exp.pop_back());
    end
    host_select <= 1'b0;
    @(posedge qdr_clk);
  endtask

  task automatic host_write(input qdr_addr_t w, input logic hi, input host_data_t d,
                            input host_be_t be);
    mirror[w] = apply_mask(mirror_get(w), pack_word(hi, d), pack_be(hi, be));
    host_access(`SNIFF_BASE + (32'(w) << 3) + (32'(hi) << 2), 1'b0, d, be, '0);
  endtask

  task automatic host_read(input qdr_addr_t w, input logic hi);
    host_access(`SNIFF_BASE + (32'(w) << 3) + (32'(hi) << 2), 1'b1, '0, '0,
                host_view(mirror_get(w), hi));
  endtask

  // one strobe held until slave_ack takes it
  task automatic fabric_cmd(input logic wr, input qdr_addr_t a, input qdr_word_t d,
                            input qdr_be_t be);
    int n;
    slave_wr_strb <= wr;
    slave_rd_strb <= !wr;
    slave_addr    <= a;
    slave_wr_data <= d;
    slave_wr_be   <= be;
    n = 0;
    do begin
      @(posedge qdr_clk);
      n++;
    end while (!slave_ack && n < 20);
    if (!slave_ack) begin
      timeouts++;
      $display("fabric strobe not accepted within 20 cycles");
    end else if (wr) begin
      mirror[a] = apply_mask(mirror_get(a), d, be);
      fab_wr_sent++;
    end else begin
      fab_exp.push_back(mirror_get(a));
    end
  endtask

  task automatic fabric_idle();
    slave_wr_strb <= 1'b0;
    slave_rd_strb <= 1'b0;
  endtask

  // fabric uses the upper half of the array and host the bottom
  task automatic fabric_stream(input int cnt);
    qdr_word_t d;
    for (int i = 0; i < cnt; i++) begin
      d = {$random(seed), $random(seed), $random(seed)};
      fabric_cmd($random(seed) & 1, 21'h100000 | ($random(seed) & 21'hf), d,
                 $random(seed) & 4'hf);
    end
    fabric_idle();
  endtask

  task automatic probe_unmapped(input host_addr_t a);
    host_addr   <= a;
    host_rnw    <= 1'b1;
    host_select <= 1'b1;
    for (int n = 0; n < 30; n++) begin
      @(posedge qdr_clk);
      if (host_ack) begin
        errors++;
        $display("unmapped address %h was acknowledged", a);
      end
      if (host_tout_sup) begin
        errors++;
        $display("host_tout_sup raised for unmapped address %h", a);
      end
    end
    host_select <= 1'b0;
    @(posedge qdr_clk);
  endtask

  // ====================================================================
  // main sequence
  // ====================================================================

  initial begin
    host_data_t hd;
    host_be_t   be;
    qdr_addr_t  w;
    int         n;
    qdr_clk = 1'b0;
    qdr_rst <= 1'b1;
    host_addr <= '0;
    host_be <= '0;
    host_wdata <= '0;
    host_rnw <= 1'b0;
    host_select <= 1'b0;
    slave_addr <= '0;
    slave_wr_data <= '0;
    slave_wr_be <= '0;
    slave_wr_strb <= 1'b0;
    slave_rd_strb <= 1'b0;
    phy_rdy <= 1'b0;
    cal_fail <= 1'b0;
    repeat (3) @(posedge qdr_clk);
    qdr_rst <= 1'b0;
    @(posedge qdr_clk);

    // host writes to both halves with read back
    for (int i = 0; i < 12; i++) begin
      w  = $random(seed) & 21'h1f;
      hd = $random(seed);
      host_write(w, i[0], hd, 4'hf);
      host_read(w, i[0]);
    end

    // partial byte enables checked as whole words from the fabric side
    for (int i = 0; i < 8; i++) begin
      w  = $random(seed) & 21'h1f;
      be = $random(seed);
      host_write(w, $random(seed) & 1, $random(seed), be);
      fabric_cmd(1'b0, w, '0, '0);
      fabric_idle();
      @(posedge qdr_clk);
    end

    // fabric only
    fabric_stream(40);
    @(posedge qdr_clk);

    // fabric stream against host traffic
    fork
      fabric_stream(120);
      for (int j = 0; j < 10; j++) begin
        w = $random(seed) & 21'h1f;
        host_write(w, j[0], $random(seed), 4'hf);
        host_read(w, j[0]);
      end
    join

    // status window
    // phy_rdy in bit 0 and cal_fail in bit 1
    phy_rdy  <= 1'b1;
    cal_fail <= 1'b0;
    repeat (4) @(posedge qdr_clk);
    host_access(`CFG_BASE, 1'b1, '0, '0, 32'h1);
    phy_rdy  <= 1'b0;
    cal_fail <= 1'b1;
    repeat (4) @(posedge qdr_clk);
    host_access(`CFG_BASE, 1'b1, '0, '0, 32'h2);
    host_access(`CFG_BASE + 4, 1'b0, 32'h1, 4'hf, '0);
    if (qdr_reset !== 1'b1) begin
      errors++;
      $display("error %0t qdr_reset exp 1 got %b", $time, qdr_reset);
    end
    host_access(`CFG_BASE + 4, 1'b1, '0, '0, 32'h1);
    host_access(`CFG_BASE + 4, 1'b0, 32'h0, 4'hf, '0);
    if (qdr_reset !== 1'b0) begin
      errors++;
      $display("error %0t qdr_reset exp 0 got %b", $time, qdr_reset);
    end
    hd = $random(seed);
    host_access(`CFG_BASE + 8, 1'b0, hd, 4'hf, '0);
    host_access(`CFG_BASE + 8, 1'b1, '0, '0, hd);
    host_access(`CFG_BASE + 12, 1'b1, '0, '0, 32'h0);

    // outside both windows
    probe_unmapped(32'h0300_0000);
    probe_unmapped(32'h0000_2000);

    // drain outstanding fabric reads
    n = 0;
    while (fab_exp.size() != 0 && n < 50) begin
      @(posedge qdr_clk);
      n++;
    end
    if (fab_exp.size() != 0) begin
      timeouts++;
      $display("%0d fabric reads never returned", fab_exp.size());
    end
    if (fab_wr_seen != fab_wr_sent) begin
      errors++;
      $display("error %0t fabric writes exp %0d got %0d", $time, fab_wr_sent, fab_wr_seen);
    end

    $display("errors %0d timeouts %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- qdr_sniffer.f
+incdir+include
src/qdr_types_pkg.sv
src/host_bus_pkg.sv
src/host_slave_port.sv
src/backdoor_bridge.sv
src/sniff_arbiter.sv
src/qdr_status_regs.sv
src/qdr_sniffer_top.sv
verification/qdr_mem_model.sv
verification/qdr_sniffer_tb.sv

//--- Bender.yml
package:
  name: qdr_sniffer

sources:
  - include_dirs:
      - include
    files:
      - src/qdr_types_pkg.sv
      - src/host_bus_pkg.sv
      - src/host_slave_port.sv
      - src/backdoor_bridge.sv
      - src/sniff_arbiter.sv
      - src/qdr_status_regs.sv
      - src/qdr_sniffer_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/qdr_mem_model.sv
      - verification/qdr_sniffer_tb.sv
